//--- rtl/mips_pkg.sv
package mips_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;

  // ========================================
  // instruction encodings
  // ========================================
  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_J     = 6'h02;
  localparam opcode_t OP_JAL   = 6'h03;
  localparam opcode_t OP_BEQ   = 6'h04;
  localparam opcode_t OP_BNE   = 6'h05;
  localparam opcode_t OP_ADDIU = 6'h09;
  localparam opcode_t OP_LUI   = 6'h0f;
  localparam opcode_t OP_LW    = 6'h23;
  localparam opcode_t OP_SW    = 6'h2b;

  localparam funct_t FN_JR   = 6'h08;
  localparam funct_t FN_ADDU = 6'h21;
  localparam funct_t FN_SUBU = 6'h23;
  localparam funct_t FN_AND  = 6'h24;
  localparam funct_t FN_OR   = 6'h25;
  localparam funct_t FN_SLT  = 6'h2a;

  localparam reg_idx_t REG_RA = 5'd31; // link register.

  // ========================================
  // control
  // ========================================
  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_LUI} alu_op_t;
  typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} branch_kind_t;
  typedef enum logic [1:0] {JMP_NONE, JMP_IMM, JMP_LINK, JMP_REG} jump_kind_t;
  typedef enum logic [1:0] {FWD_NONE = 2'b00, FWD_W = 2'b01, FWD_M = 2'b10} fwd_sel_t;

  // all zero is a bubble.
  typedef struct packed {
    logic         reg_write;
    logic         mem_to_reg;
    logic         mem_write;
    logic         alu_src_imm;
    logic         reg_dst_rd;
    logic         link;
    alu_op_t      alu_op;
    branch_kind_t branch;
    jump_kind_t   jump;
  } ctrl_t;

  // ========================================
  // pipeline registers
  // ========================================
  typedef struct packed {
    ctrl_t    ctrl;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t write_reg;
    word_t    rd_a;
    word_t    rd_b;
    word_t    imm;
    word_t    pc4;
  } de_reg_t;

  typedef struct packed {
    logic     reg_write;
    logic     mem_to_reg;
    logic     mem_write;
    reg_idx_t write_reg;
    word_t    alu_out; // also carries the link value.
    word_t    write_data;
  } em_reg_t;

  typedef struct packed {
    logic     reg_write;
    logic     mem_to_reg;
    reg_idx_t write_reg;
    word_t    alu_out;
    word_t    read_data;
  } mw_reg_t;

endpackage : mips_pkg

//--- rtl/alu.sv
`timescale 1ns/1ns

module alu (
  input  mips_pkg::alu_op_t op_i,
  input  mips_pkg::word_t   a_i,
  input  mips_pkg::word_t   b_i,
  output mips_pkg::word_t   y_o
);

  logic lt_signed;

  assign lt_signed = $signed(a_i) < $signed(b_i);

  always_comb begin
    case (op_i)
      mips_pkg::ALU_ADD: y_o = a_i + b_i;
      mips_pkg::ALU_SUB: y_o = a_i - b_i;
      mips_pkg::ALU_AND: y_o = a_i & b_i;
      mips_pkg::ALU_OR:  y_o = a_i | b_i;
      mips_pkg::ALU_SLT: y_o = {31'd0, lt_signed};
      mips_pkg::ALU_LUI: y_o = {b_i[15:0], 16'h0000}; // a is ignored.
      default:           y_o = '0;
    endcase
  end

endmodule : alu

//--- rtl/reg_file.sv
`timescale 1ns/1ns

module reg_file (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  mips_pkg::reg_idx_t ra1_i,
  input  mips_pkg::reg_idx_t ra2_i,
  input  mips_pkg::reg_idx_t wa_i,
  input  logic               we_i,
  input  mips_pkg::word_t    wd_i,
  output mips_pkg::word_t    rd1_o,
  output mips_pkg::word_t    rd2_o
);

  mips_pkg::word_t regs_q [32];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && wa_i != '0) begin
      regs_q[wa_i] <= wd_i;
    end
  end

  // write-through read.
  assign rd1_o = (we_i && wa_i != '0 && wa_i == ra1_i) ? wd_i : regs_q[ra1_i];
  assign rd2_o = (we_i && wa_i != '0 && wa_i == ra2_i) ? wd_i : regs_q[ra2_i];

endmodule : reg_file

//--- rtl/ctrl_decoder.sv
`timescale 1ns/1ns

module ctrl_decoder (
  input  mips_pkg::word_t instr_i,
  output mips_pkg::ctrl_t ctrl_o
);

  mips_pkg::opcode_t opcode;
  mips_pkg::funct_t  funct;

  assign opcode = instr_i[31:26];
  assign funct  = instr_i[5:0];

  always_comb begin
    ctrl_o = '0; // unknown encodings end up here.
    case (opcode)
      mips_pkg::OP_RTYPE: begin
        ctrl_o.reg_write  = 1'b1;
        ctrl_o.reg_dst_rd = 1'b1;
        case (funct)
          mips_pkg::FN_ADDU: ctrl_o.alu_op = mips_pkg::ALU_ADD;
          mips_pkg::FN_SUBU: ctrl_o.alu_op = mips_pkg::ALU_SUB;
          mips_pkg::FN_AND:  ctrl_o.alu_op = mips_pkg::ALU_AND;
          mips_pkg::FN_OR:   ctrl_o.alu_op = mips_pkg::ALU_OR;
          mips_pkg::FN_SLT:  ctrl_o.alu_op = mips_pkg::ALU_SLT;
          mips_pkg::FN_JR: begin
            ctrl_o = '0;
            ctrl_o.jump = mips_pkg::JMP_REG;
          end
          default: ctrl_o = '0;
        endcase
      end
      mips_pkg::OP_ADDIU, mips_pkg::OP_LUI: begin
        ctrl_o.reg_write   = 1'b1;
        ctrl_o.alu_src_imm = 1'b1;
        ctrl_o.alu_op      = (opcode == mips_pkg::OP_LUI) ? mips_pkg::ALU_LUI
                                                          : mips_pkg::ALU_ADD;
      end
      mips_pkg::OP_LW: begin
        ctrl_o.reg_write   = 1'b1;
        ctrl_o.mem_to_reg  = 1'b1;
        ctrl_o.alu_src_imm = 1'b1;
      end
      mips_pkg::OP_SW: begin
        ctrl_o.mem_write   = 1'b1;
        ctrl_o.alu_src_imm = 1'b1;
      end
      mips_pkg::OP_BEQ: ctrl_o.branch = mips_pkg::BR_EQ;
      mips_pkg::OP_BNE: ctrl_o.branch = mips_pkg::BR_NE;
      mips_pkg::OP_J:   ctrl_o.jump   = mips_pkg::JMP_IMM;
      mips_pkg::OP_JAL: begin
        ctrl_o.jump      = mips_pkg::JMP_LINK;
        ctrl_o.link      = 1'b1; // pc+4 into r31.
        ctrl_o.reg_write = 1'b1;
      end
      default: ctrl_o = '0;
    endcase
  end

endmodule : ctrl_decoder

//--- rtl/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit (
  input  mips_pkg::reg_idx_t     rs_d_i,
  input  mips_pkg::reg_idx_t     rt_d_i,
  input  mips_pkg::branch_kind_t branch_d_i,
  input  mips_pkg::jump_kind_t   jump_d_i,
  input  logic                   pc_src_d_i,
  input  mips_pkg::reg_idx_t     rs_e_i,
  input  mips_pkg::reg_idx_t     rt_e_i,
  input  mips_pkg::reg_idx_t     write_reg_e_i,
  input  logic                   mem_to_reg_e_i,
  input  logic                   reg_write_e_i,
  input  mips_pkg::reg_idx_t     write_reg_m_i,
  input  logic                   mem_to_reg_m_i,
  input  logic                   reg_write_m_i,
  input  mips_pkg::reg_idx_t     write_reg_w_i,
  input  logic                   reg_write_w_i,
  input  logic                   stall_mem_i,
  output logic                   stall_f_o,
  output logic                   stall_d_o,
  output logic                   flush_d_o,
  output logic                   forward_a_d_o,
  output logic                   forward_b_d_o,
  output logic                   stall_e_o,
  output logic                   flush_e_o,
  output mips_pkg::fwd_sel_t     forward_a_e_o,
  output mips_pkg::fwd_sel_t     forward_b_e_o,
  output logic                   stall_m_o,
  output logic                   stall_w_o
);

  logic lw_stall;
  logic branch_stall;
  logic reads_reg_d; // branch or jr reads operands in decode.

  function automatic mips_pkg::fwd_sel_t fwd_sel(mips_pkg::reg_idx_t src);
    if (src != '0 && src == write_reg_m_i && reg_write_m_i) return mips_pkg::FWD_M;
    if (src != '0 && src == write_reg_w_i && reg_write_w_i) return mips_pkg::FWD_W;
    return mips_pkg::FWD_NONE;
  endfunction

  always_comb begin
    forward_a_e_o = fwd_sel(rs_e_i);
    forward_b_e_o = fwd_sel(rt_e_i);
  end

  // decode takes M only and W through the register file.
  assign forward_a_d_o = rs_d_i != '0 && rs_d_i == write_reg_m_i && reg_write_m_i;
  assign forward_b_d_o = rt_d_i != '0 && rt_d_i == write_reg_m_i && reg_write_m_i;

  assign lw_stall = mem_to_reg_e_i && write_reg_e_i != '0
                    && (rs_d_i == write_reg_e_i || rt_d_i == write_reg_e_i);

  assign reads_reg_d = branch_d_i != mips_pkg::BR_NONE || jump_d_i == mips_pkg::JMP_REG;
  assign branch_stall = reads_reg_d
      && (reg_write_e_i && write_reg_e_i != '0
          && (rs_d_i == write_reg_e_i || rt_d_i == write_reg_e_i)
       || mem_to_reg_m_i && write_reg_m_i != '0
          && (rs_d_i == write_reg_m_i || rt_d_i == write_reg_m_i));

  assign stall_w_o = stall_mem_i;
  assign stall_m_o = stall_w_o;
  assign stall_e_o = stall_m_o;
  assign stall_d_o = lw_stall || branch_stall || stall_e_o;
  assign stall_f_o = stall_d_o;

  assign flush_e_o = lw_stall || branch_stall; // bubble into E.
  assign flush_d_o = (pc_src_d_i || jump_d_i != mips_pkg::JMP_NONE) && !stall_d_o;

endmodule : hazard_unit

//--- rtl/mips_core.sv
`timescale 1ns/1ns

module mips_core #(
  parameter mips_pkg::word_t RESET_PC = '0
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  output mips_pkg::word_t    imem_addr_o,
  input  mips_pkg::word_t    imem_data_i,
  output mips_pkg::word_t    dmem_addr_o,
  output mips_pkg::word_t    dmem_wdata_o,
  output logic               dmem_we_o,
  input  mips_pkg::word_t    dmem_rdata_i,
  input  logic               mem_stall_i,
  output logic               wb_valid_o,
  output mips_pkg::reg_idx_t wb_reg_o,
  output mips_pkg::word_t    wb_data_o
);

  logic stall_f, stall_d, flush_d, fwd_a_d, fwd_b_d;
  logic stall_e, flush_e, stall_m, stall_w;
  mips_pkg::fwd_sel_t fwd_a_e, fwd_b_e;

  mips_pkg::word_t pc_q, pc_next, pc4_f;
  mips_pkg::word_t fd_instr_q, fd_pc4_q;
  mips_pkg::de_reg_t de_d, de_q;
  mips_pkg::em_reg_t em_d, em_q;
  mips_pkg::mw_reg_t mw_d, mw_q;

  // ========================================
  // fetch
  // ========================================
  assign imem_addr_o = pc_q;
  assign pc4_f       = pc_q + 32'd4;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= RESET_PC;
    end else if (!stall_f) begin
      pc_q <= pc_next;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fd_instr_q <= '0; // decodes as a bubble.
      fd_pc4_q   <= '0;
    end else if (!stall_d) begin
      fd_instr_q <= flush_d ? '0 : imem_data_i;
      fd_pc4_q   <= pc4_f;
    end
  end

  // ========================================
  // decode
  // ========================================
  mips_pkg::ctrl_t ctrl_d;
  mips_pkg::word_t rd1_d, rd2_d, src_a_d, src_b_d, imm_d;
  mips_pkg::word_t br_target_d, j_target_d;
  mips_pkg::word_t result_w;
  logic pc_src_d;

  ctrl_decoder ctrl_decoder_i (
    .instr_i (fd_instr_q),
    .ctrl_o  (ctrl_d)
  );

  reg_file reg_file_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .ra1_i    (fd_instr_q[25:21]),
    .ra2_i    (fd_instr_q[20:16]),
    .wa_i     (mw_q.write_reg),
    .we_i     (wb_valid_o),
    .wd_i     (result_w),
    .rd1_o    (rd1_d),
    .rd2_o    (rd2_d)
  );

  assign imm_d   = {{16{fd_instr_q[15]}}, fd_instr_q[15:0]};
  assign src_a_d = fwd_a_d ? em_q.alu_out : rd1_d;
  assign src_b_d = fwd_b_d ? em_q.alu_out : rd2_d;

  assign pc_src_d = (ctrl_d.branch == mips_pkg::BR_EQ && src_a_d == src_b_d)
                 || (ctrl_d.branch == mips_pkg::BR_NE && src_a_d != src_b_d);
  assign br_target_d = fd_pc4_q + {imm_d[29:0], 2'b00};
  assign j_target_d  = {fd_pc4_q[31:28], fd_instr_q[25:0], 2'b00};

  always_comb begin
    case (ctrl_d.jump)
      mips_pkg::JMP_REG:                   pc_next = src_a_d;
      mips_pkg::JMP_IMM, mips_pkg::JMP_LINK: pc_next = j_target_d;
      default:                             pc_next = pc_src_d ? br_target_d : pc4_f;
    endcase
  end

  always_comb begin
    de_d.ctrl  = ctrl_d;
    de_d.rs    = fd_instr_q[25:21];
    de_d.rt    = fd_instr_q[20:16];
    de_d.rd_a  = rd1_d; // E forwarding covers M and W.
    de_d.rd_b  = rd2_d;
    de_d.imm   = imm_d;
    de_d.pc4   = fd_pc4_q;
    if (ctrl_d.link) begin
      de_d.write_reg = mips_pkg::REG_RA;
    end else begin
      de_d.write_reg = ctrl_d.reg_dst_rd ? fd_instr_q[15:11] : fd_instr_q[20:16];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      de_q <= '0;
    end else if (!stall_e) begin
      de_q <= flush_e ? '0 : de_d;
    end
  end

  // ========================================
  // execute
  // ========================================
  mips_pkg::word_t src_a_e, wdata_e, alu_y_e;

  always_comb begin
    case (fwd_a_e)
      mips_pkg::FWD_M: src_a_e = em_q.alu_out;
      mips_pkg::FWD_W: src_a_e = result_w;
      default:         src_a_e = de_q.rd_a;
    endcase
    case (fwd_b_e)
      mips_pkg::FWD_M: wdata_e = em_q.alu_out;
      mips_pkg::FWD_W: wdata_e = result_w;
      default:         wdata_e = de_q.rd_b;
    endcase
  end

  alu alu_i (
    .op_i (de_q.ctrl.alu_op),
    .a_i  (src_a_e),
    .b_i  (de_q.ctrl.alu_src_imm ? de_q.imm : wdata_e),
    .y_o  (alu_y_e)
  );

  assign em_d = '{
    reg_write:  de_q.ctrl.reg_write,
    mem_to_reg: de_q.ctrl.mem_to_reg,
    mem_write:  de_q.ctrl.mem_write,
    write_reg:  de_q.write_reg,
    alu_out:    de_q.ctrl.link ? de_q.pc4 : alu_y_e,
    write_data: wdata_e
  };

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      em_q <= '0;
    end else if (!stall_m) begin
      em_q <= em_d;
    end
  end

  // ========================================
  // memory and writeback
  // ========================================
  assign dmem_addr_o  = em_q.alu_out;
  assign dmem_wdata_o = em_q.write_data;
  assign dmem_we_o    = em_q.mem_write; // held steady through a stall.

  assign mw_d = '{
    reg_write:  em_q.reg_write,
    mem_to_reg: em_q.mem_to_reg,
    write_reg:  em_q.write_reg,
    alu_out:    em_q.alu_out,
    read_data:  dmem_rdata_i
  };

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mw_q <= '0;
    end else if (!stall_w) begin
      mw_q <= mw_d;
    end
  end

  assign result_w   = mw_q.mem_to_reg ? mw_q.read_data : mw_q.alu_out;
  assign wb_valid_o = mw_q.reg_write && !stall_w; // one write per instruction.
  assign wb_reg_o   = mw_q.write_reg;
  assign wb_data_o  = result_w;

  hazard_unit hazard_unit_i (
    .rs_d_i         (de_d.rs),
    .rt_d_i         (de_d.rt),
    .branch_d_i     (ctrl_d.branch),
    .jump_d_i       (ctrl_d.jump),
    .pc_src_d_i     (pc_src_d),
    .rs_e_i         (de_q.rs),
    .rt_e_i         (de_q.rt),
    .write_reg_e_i  (de_q.write_reg),
    .mem_to_reg_e_i (de_q.ctrl.mem_to_reg),
    .reg_write_e_i  (de_q.ctrl.reg_write),
    .write_reg_m_i  (em_q.write_reg),
    .mem_to_reg_m_i (em_q.mem_to_reg),
    .reg_write_m_i  (em_q.reg_write),
    .write_reg_w_i  (mw_q.write_reg),
    .reg_write_w_i  (mw_q.reg_write),
    .stall_mem_i    (mem_stall_i),
    .stall_f_o      (stall_f),
    .stall_d_o      (stall_d),
    .flush_d_o      (flush_d),
    .forward_a_d_o  (fwd_a_d),
    .forward_b_d_o  (fwd_b_d),
    .stall_e_o      (stall_e),
    .flush_e_o      (flush_e),
    .forward_a_e_o  (fwd_a_e),
    .forward_b_e_o  (fwd_b_e),
    .stall_m_o      (stall_m),
    .stall_w_o      (stall_w)
  );

endmodule : mips_core

//--- sim/tb_mips_core.sv
`timescale 1ns/1ns

module tb_mips_core;

  localparam int MEM_WORDS      = 64;
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int DRAIN_CYCLES   = 50;

  // a register number or a store address plus its data.
  typedef struct packed {
    mips_pkg::word_t key;
    mips_pkg::word_t data;
  } trace_ev_t;

  logic               clk_i;
  logic               arst_n_i;
  logic               mem_stall_i;
  mips_pkg::word_t    imem_addr_o;
  mips_pkg::word_t    imem_data_i;
  mips_pkg::word_t    dmem_addr_o;
  mips_pkg::word_t    dmem_wdata_o;
  logic               dmem_we_o;
  mips_pkg::word_t    dmem_rdata_i;
  logic               wb_valid_o;
  mips_pkg::reg_idx_t wb_reg_o;
  mips_pkg::word_t    wb_data_o;

  mips_pkg::word_t imem [MEM_WORDS];
  mips_pkg::word_t dmem [MEM_WORDS];
  trace_ev_t       wb_expect_q [$];
  trace_ev_t       st_expect_q [$];
  int              errors;
  int              wb_seen;
  int              st_seen;
  integer          seed;
  logic            running;

  mips_core #(
    .RESET_PC ('0)
  ) dut_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .imem_addr_o  (imem_addr_o),
    .imem_data_i  (imem_data_i),
    .dmem_addr_o  (dmem_addr_o),
    .dmem_wdata_o (dmem_wdata_o),
    .dmem_we_o    (dmem_we_o),
    .dmem_rdata_i (dmem_rdata_i),
    .mem_stall_i  (mem_stall_i),
    .wb_valid_o   (wb_valid_o),
    .wb_reg_o     (wb_reg_o),
    .wb_data_o    (wb_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ========================================
  // memories
  // ========================================
  assign imem_data_i  = imem[imem_addr_o[7:2]];
  assign dmem_rdata_i = dmem[dmem_addr_o[7:2]]; // combinational read.

  always @(posedge clk_i) begin
    if (arst_n_i && dmem_we_o && !mem_stall_i) begin
      dmem[dmem_addr_o[7:2]] <= dmem_wdata_o;
    end
  end

  // roughly one stall cycle in four.
  always @(posedge clk_i) begin
    if (running) begin
      mem_stall_i <= ($random(seed) & 3) == 0;
    end else begin
      mem_stall_i <= 1'b0;
    end
  end

  task automatic check_value(input string name, input mips_pkg::word_t expected,
                             input mips_pkg::word_t actual);
    if (actual !== expected) begin
      errors++;
      $display("** Error: %s expected %h, got %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic read_testdata();
    int               fd;
    int               n;
    int               iaddr;
    logic [7:0]       tag;
    mips_pkg::word_t  a;
    mips_pkg::word_t  b;
    logic [1023:0]    rest;
    trace_ev_t        ev;
    fd = $fopen("sim/mips_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open sim/mips_testdata.txt");
    end else begin
      iaddr = 0;
      while (!$feof(fd)) begin
        n = $fscanf(fd, "%s", tag);
        if (n == 1) begin
          if (tag == "I") begin
            n = $fscanf(fd, "%h", a);
            imem[iaddr[5:0]] = a;
            iaddr++;
          end else if (tag == "W" || tag == "S") begin
            n = $fscanf(fd, "%h %h", a, b);
            ev.key  = a;
            ev.data = b;
            if (tag == "W") wb_expect_q.push_back(ev);
            else st_expect_q.push_back(ev);
          end else begin
            n = $fgets(rest, fd); // comment line.
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ========================================
  // trace checks
  // ========================================
  always @(negedge clk_i) begin : trace_check
    trace_ev_t ev;
    if (arst_n_i && wb_valid_o) begin
      if (wb_expect_q.size() == 0) begin
        errors++;
        $display("writeback to r%0d at %0t was not expected", wb_reg_o, $time);
      end else begin
        ev = wb_expect_q.pop_front();
        check_value("wb_reg_o", ev.key, {27'd0, wb_reg_o});
        check_value("wb_data_o", ev.data, wb_data_o);
        wb_seen++;
      end
    end
    if (arst_n_i && dmem_we_o && !mem_stall_i) begin // store commits next edge.
      if (st_expect_q.size() == 0) begin
        errors++;
        $display("store to %h at %0t was not expected", dmem_addr_o, $time);
      end else begin
        ev = st_expect_q.pop_front();
        check_value("dmem_addr_o", ev.key, dmem_addr_o);
        check_value("dmem_wdata_o", ev.data, dmem_wdata_o);
        st_seen++;
      end
    end
  end

  initial begin
    int cycles;
    errors      = 0;
    wb_seen     = 0;
    st_seen     = 0;
    seed        = 51382;
    running     <= 1'b0;
    arst_n_i    <= 1'b0;
    mem_stall_i <= 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = 32'hfc00_0000 | (i << 2); // unknown opcode decodes as a bubble.
      dmem[i] <= 32'hc0de_0000 ^ (i << 2);
    end
    read_testdata();

    repeat (10) @(posedge clk_i);
    arst_n_i <= 1'b1;
    running  <= 1'b1;

    cycles = 0;
    while ((wb_expect_q.size() != 0 || st_expect_q.size() != 0) && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    if (wb_expect_q.size() != 0) begin
      errors++;
      $display("timeout with %0d writebacks still missing", wb_expect_q.size());
    end
    if (st_expect_q.size() != 0) begin
      errors++;
      $display("timeout with %0d stores still missing", st_expect_q.size());
    end

    // nothing more may show up while the program spins on its last jump.
    cycles = 0;
    while (cycles < DRAIN_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end

    $display("checked %0d writebacks and %0d stores, %0d errors", wb_seen, st_seen, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : tb_mips_core

//--- sim/mips_testdata.txt
# I word: instruction memory from address 0 up
# W reg data: expected writebacks, S addr data: expected stores, all hex in program order
I 2401fffb
I 3c021234
I 0020182a
I 00432021
I 00812823
I 00a43024
I 00c30025
I 00033821
I ac050008
I 8c080008
I 01074821
I ac09000c
I 8c0a000c
I 11490001
I 240b0bad
I 240c0007
I 15870001
I 240b0bad
I 11870001
I 14e30001
I 258d0001
I 08000017
I 240b0bad
I 0c00001b
I 240b0bad
I ac1f0014
I 0800001a
I 27ee0004
I 01c00008
W 01 fffffffb
W 02 12340000
W 03 00000001
W 04 12340001
W 05 12340006
W 06 12340000
W 00 12340001
W 07 00000001
W 08 12340006
W 09 12340007
W 0a 12340007
W 0c 00000007
W 0d 00000008
W 1f 00000060
W 0e 00000064
S 00000008 12340006
S 0000000c 12340007
S 00000014 00000060

//--- sources.f
rtl/mips_pkg.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/ctrl_decoder.sv
rtl/hazard_unit.sv
rtl/mips_core.sv
sim/tb_mips_core.sv

//--- Makefile
SIM = obj_dir/Vtb_mips_core

.PHONY: all run clean

all: run

$(SIM): sources.f $(wildcard rtl/*.sv sim/*.sv)
	verilator --binary --timing --top-module tb_mips_core -f sources.f -Mdir obj_dir -o Vtb_mips_core

run: $(SIM)
	./$(SIM) | awk '{ print } /^Testbench passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
